// File: logic/nocPkg.sv
package nocPkg;

  localparam int numPorts = 5;        // Local, North, East, West, South
  localparam int flitWidth = 16;
  localparam int flitIdWidth = 3;
  localparam int lengthWidth = 12;
  localparam int portIndexWidth = 3;
  localparam int dropCountWidth = 8;

  localparam logic [flitIdWidth-1:0] flitHead = 3'b001;
  localparam logic [flitIdWidth-1:0] flitBody = 3'b010;
  localparam logic [flitIdWidth-1:0] flitTail = 3'b100;

  typedef struct packed {
    logic [flitIdWidth-1:0] id;
    logic [lengthWidth-1:0] length;   // Hold budget in cycles
    logic spare;
  } flitHeader;

  typedef struct packed {
    logic [flitIdWidth-1:0] id;
    logic [flitWidth-flitIdWidth-1:0] payload;
  } flitData;

  // Header view when id is flitHead, data view otherwise
  typedef union packed {
    flitHeader header;
    flitData data;
  } flitWord;

  // One-hot port vector to port index, zero when idle
  function automatic logic [portIndexWidth-1:0] portIndex(input logic [numPorts-1:0] oneHot);
    logic [portIndexWidth-1:0] index;
    index = '0;
    for (int i = 0; i < numPorts; i++)
    begin
      if (oneHot[i])
      begin
        index = portIndexWidth'(i);
      end
    end
    return index;
  endfunction

endpackage

// File: logic/inputChannel.sv
module inputChannel
  import nocPkg::*;
#(
  parameter int fifoDepth = 4
) (
  input  logic clk,
  input  logic rst,
  input  flitWord linkFlit,
  input  logic linkValid,
  input  logic pop,
  input  logic runTimer,
  output flitWord headFlit,
  output logic request,
  output logic full,
  output logic timesUp,
  output logic [dropCountWidth-1:0] dropCount
);

  localparam int ptrWidth = $clog2(fifoDepth);

  flitWord mem [fifoDepth];
  logic [ptrWidth:0] wrPtr;                // Extra bit tells full from empty
  logic [ptrWidth:0] rdPtr;
  logic empty;
  logic pushOk;
  logic popOk;
  logic [lengthWidth-1:0] budget;
  logic [lengthWidth-1:0] count;

  assign empty = (wrPtr == rdPtr);
  assign full = (wrPtr[ptrWidth] != rdPtr[ptrWidth])
             && (wrPtr[ptrWidth-1:0] == rdPtr[ptrWidth-1:0]);
  assign pushOk = linkValid && !full;
  assign popOk = pop && !empty;

  assign request = !empty;
  assign headFlit = mem[rdPtr[ptrWidth-1:0]];
  assign timesUp = (count == budget);      // Hold budget used up

  always_ff @(posedge clk)
  begin
    if (pushOk)
    begin
      mem[wrPtr[ptrWidth-1:0]] <= linkFlit;
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      wrPtr <= '0;
      rdPtr <= '0;
    end
    else
    begin
      if (pushOk)
      begin
        wrPtr <= wrPtr + 1'b1;
      end
      if (popOk)
      begin
        rdPtr <= rdPtr + 1'b1;
      end
    end
  end

  // Flits arriving on a full channel are lost, count them
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      dropCount <= '0;
    end
    else if (linkValid && full && (dropCount != '1))
    begin
      dropCount <= dropCount + 1'b1;
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      budget <= '0;
      count <= '0;
    end
    else
    begin
      if (popOk && (headFlit.header.id == flitHead))
      begin
        budget <= headFlit.header.length;  // New packet sets the hold budget
      end
      if (runTimer)
      begin
        count <= count + 1'b1;
      end
      else
      begin
        count <= '0;
      end
    end
  end

endmodule

// File: logic/outputArbiter.sv
module outputArbiter
  import nocPkg::*;
(
  input  logic clk,
  input  logic rst,
  input  logic [numPorts-1:0] request,
  input  logic [numPorts-1:0] timesUp,
  output logic [numPorts-1:0] grant
);

  logic [numPorts-1:0] nextGrant;
  logic [portIndexWidth-1:0] holder;
  logic holderStays;

  // First requester in cyclic order from start, looking at span ports
  function automatic logic [numPorts-1:0] scanFrom(
    input logic [numPorts-1:0] req,
    input int start,
    input int span
  );
    logic [numPorts-1:0] pick;
    logic found;
    int idx;
    pick = '0;
    found = 1'b0;
    for (int k = 0; k < span; k++)
    begin
      idx = (start + k) % numPorts;
      if (!found && req[idx])
      begin
        pick[idx] = 1'b1;
        found = 1'b1;
      end
    end
    return pick;
  endfunction

  assign holder = portIndex(grant);
  assign holderStays = request[holder] && !timesUp[holder];

  always_comb
  begin
    if (grant == '0)
    begin
      nextGrant = scanFrom(request, 0, numPorts);     // Idle scan starts at Local
    end
    else if (holderStays)
    begin
      nextGrant = grant;
    end
    else
    begin
      // Holder is skipped, so a lone requester passes through idle
      nextGrant = scanFrom(request, int'(holder) + 1, numPorts - 1);
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      grant <= '0;
    end
    else
    begin
      grant <= nextGrant;
    end
  end

endmodule

// File: logic/flitSwitch.sv
module flitSwitch
  import nocPkg::*;
(
  input  logic clk,
  input  logic rst,
  input  logic [numPorts-1:0] grant,
  input  logic [numPorts-1:0] request,
  input  flitWord headFlit [numPorts],
  output logic [numPorts-1:0] pop,
  output flitWord outFlit,
  output logic outValid,
  output logic [portIndexWidth-1:0] outSource
);

  flitWord selFlit;

  assign pop = grant & request;            // At most one bit, grant is one-hot

  always_comb
  begin
    selFlit = '0;
    for (int i = 0; i < numPorts; i++)
    begin
      if (grant[i])
      begin
        selFlit.data = headFlit[i].data;
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      outValid <= 1'b0;
    end
    else
    begin
      outValid <= |pop;
    end
  end

  always_ff @(posedge clk)
  begin
    if (|pop)
    begin
      outFlit <= selFlit;
      outSource <= portIndex(grant);
    end
  end

endmodule

// File: logic/routerOutputStage.sv
module routerOutputStage
  import nocPkg::*;
#(
  parameter int fifoDepth = 4
) (
  input  logic clk,
  input  logic rst,
  input  flitWord linkFlit [numPorts],
  input  logic [numPorts-1:0] linkValid,
  output logic [numPorts-1:0] channelFull,
  output logic [dropCountWidth-1:0] dropCount [numPorts],
  output logic [numPorts-1:0] grant,
  output flitWord outFlit,
  output logic outValid,
  output logic [portIndexWidth-1:0] outSource
);

  logic [numPorts-1:0] request;
  logic [numPorts-1:0] timesUp;
  logic [numPorts-1:0] pop;
  flitWord headFlit [numPorts];

  // One channel per link, fed straight from the link ports
  for (genvar i = 0; i < numPorts; i++)
  begin : genChannel
    inputChannel #(
      .fifoDepth(fifoDepth)
    ) channel (
      .clk      (clk),
      .rst      (rst),
      .linkFlit (linkFlit[i]),
      .linkValid(linkValid[i]),
      .pop      (pop[i]),
      .runTimer (grant[i]),      // Timer runs only while holding the output
      .headFlit (headFlit[i]),
      .request  (request[i]),
      .full     (channelFull[i]),
      .timesUp  (timesUp[i]),
      .dropCount(dropCount[i])
    );
  end

  outputArbiter arbiter (
    .clk    (clk),
    .rst    (rst),
    .request(request),
    .timesUp(timesUp),
    .grant  (grant)
  );

  flitSwitch outSwitch (
    .clk      (clk),
    .rst      (rst),
    .grant    (grant),
    .request  (request),
    .headFlit (headFlit),
    .pop      (pop),
    .outFlit  (outFlit),
    .outValid (outValid),
    .outSource(outSource)
  );

endmodule

// File: tb/arbiter_properties.sv
module arbiterProperties
  import nocPkg::*;
(
  input logic clk,
  input logic rst,
  input logic [numPorts-1:0] request,
  input logic [numPorts-1:0] timesUp,
  input logic [numPorts-1:0] grant
);
  timeunit 1ns;
  timeprecision 1ps;

  int failCount = 0;                       // Read by the testbench at the end

  task automatic flagFailure(input string msg);
    $error("%s", msg);
    failCount++;
  endtask

  grantOneHot: assert property (@(posedge clk) disable iff (rst) $onehot0(grant))
    else flagFailure("grant has more than one bit set");

  grantResetZero: assert property (@(posedge clk) rst |=> (grant == '0))
    else flagFailure("grant not zero after reset");

  // Holder with a live request and budget left keeps the output
  holderKeeps: assert property (@(posedge clk) disable iff (rst)
    ((grant != '0) && ((request & grant) != '0) && ((timesUp & grant) == '0))
    |=> (grant == $past(grant)))
    else flagFailure("holder lost the grant early");

  grantNeedsRequest: assert property (@(posedge clk) disable iff (rst)
    (grant != '0) |-> (($past(request) & grant) != '0))
    else flagFailure("grant given to a port without request");

endmodule

bind outputArbiter arbiterProperties props (.*);

// File: tb/routerOutputStageTb.sv
module routerOutputStageTb
  import nocPkg::*;
();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int fifoDepth = 4;
  localparam int pushCycles = 300 + 60 + 150 + 150 + 40;   // Sum of all phase lengths
  localparam int timeoutLimit = 2 * numPorts * pushCycles + 200;

  logic clk;
  logic rst;
  flitWord linkFlit [numPorts];
  logic [numPorts-1:0] linkValid;
  logic [numPorts-1:0] channelFull;
  logic [dropCountWidth-1:0] dropCount [numPorts];
  logic [numPorts-1:0] grant;
  flitWord outFlit;
  logic outValid;
  logic [portIndexWidth-1:0] outSource;

  flitWord expQ [numPorts][$];             // Accepted flits per port, push order
  int expDrop [numPorts];
  int pktLeft [numPorts];
  int seqNo [numPorts];
  bit [31:0] lcgState = 32'hb501;
  int mismatchCount = 0;
  int otherCount = 0;
  int cycles = 0;
  bit rotateCheck = 0;
  bit prevValid = 0;
  int runSrc = 0;
  int runLen = 0;

  routerOutputStage #(
    .fifoDepth(fifoDepth)
  ) DUT (
    .clk(clk), .rst(rst), .linkFlit(linkFlit), .linkValid(linkValid),
    .channelFull(channelFull), .dropCount(dropCount), .grant(grant),
    .outFlit(outFlit), .outValid(outValid), .outSource(outSource)
  );

  initial
  begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  function automatic int unsigned nextRand();
    lcgState = lcgState * 32'd1103515245 + 32'd12345;
    return lcgState >> 16;
  endfunction

  function automatic logic [lengthWidth-1:0] holdLen(input int p);
    return lengthWidth'(p + 2);            // Fixed budget per port
  endfunction

  // Reference flit builder: head carries the budget, others port and sequence
  function automatic flitWord buildFlit(input int p, input logic [flitIdWidth-1:0] id, input int s);
    flitWord f;
    f = '0;
    if (id == flitHead)
    begin
      f.header.id = flitHead;
      f.header.length = holdLen(p);
    end
    else
    begin
      f.data.id = id;
      f.data.payload = {3'(p), 10'(s)};
    end
    return f;
  endfunction

  function automatic flitWord nextFlit(input int p);
    flitWord f;
    if (pktLeft[p] == 0)
    begin
      pktLeft[p] = nextRand() % 6;         // Packet of 1 to 6 flits
      f = buildFlit(p, flitHead, 0);
    end
    else
    begin
      f = buildFlit(p, (pktLeft[p] == 1) ? flitTail : flitBody, seqNo[p]);
      seqNo[p]++;
      pktLeft[p]--;
    end
    return f;
  endfunction

  task automatic logMismatch(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    mismatchCount++;
    $display("mismatch %s expected %h actual %h", name, expected, actual);
  endtask

  task automatic reportFailure(input string msg);
    otherCount++;
    $display("%s", msg);
  endtask

  // Records what the DUT takes at this edge, then drives the next pushes
  task automatic stepCycle(input logic [numPorts-1:0] active, input int pct, input bit ignoreFull);
    @(posedge clk);
    for (int p = 0; p < numPorts; p++)
    begin
      if (linkValid[p] && channelFull[p])
      begin
        if (expDrop[p] != 255)
          expDrop[p]++;
      end
      else if (linkValid[p])
      begin
        expQ[p].push_back(linkFlit[p]);
      end
      if (active[p] && (ignoreFull || !channelFull[p]) && ((nextRand() % 100) < pct))
      begin
        linkFlit[p] <= nextFlit(p);
        linkValid[p] <= 1'b1;
      end
      else
      begin
        linkValid[p] <= 1'b0;
      end
    end
  endtask

  task automatic drainAll();
    int pending;
    pending = 1;
    while (pending != 0)
    begin
      stepCycle('0, 0, 1'b0);
      pending = 0;
      for (int p = 0; p < numPorts; p++)
        pending += expQ[p].size();
    end
    repeat (3) stepCycle('0, 0, 1'b0);
  endtask

  task automatic applyReset();
    rst <= 1'b1;
    linkValid <= '0;
    repeat (4) @(posedge clk);
    rst <= 1'b0;
    @(posedge clk);
    assert (outValid == 1'b0) else logMismatch("outValid", 0, outValid);
    assert (grant == '0) else logMismatch("grant", 0, grant);
    assert (channelFull == '0) else logMismatch("channelFull", 0, channelFull);
    for (int p = 0; p < numPorts; p++)
    begin
      assert (dropCount[p] == '0)
        else logMismatch($sformatf("dropCount[%0d]", p), 0, dropCount[p]);
      expDrop[p] = 0;
    end
  endtask

  // Output compare with run tracking for hold budget and rotation
  always @(posedge clk)
  begin
    flitWord expected;
    int src;
    src = int'(outSource);
    if (!rst && outValid)
    begin
      if (src >= numPorts)
      begin
        reportFailure($sformatf("Flit came out with source index %0d, which is no port", src));
      end
      else if (expQ[src].size() == 0)
      begin
        reportFailure($sformatf("Port %0d sent a flit that was never accepted", src));
      end
      else
      begin
        expected = expQ[src].pop_front();
        assert (outFlit == expected)
          else logMismatch($sformatf("outFlit[%0d]", src), expected, outFlit);
        if (prevValid && (src == runSrc))
        begin
          runLen++;
        end
        else
        begin
          if (prevValid && rotateCheck)
            assert (src == (runSrc + 1) % numPorts)
              else logMismatch("outSource", (runSrc + 1) % numPorts, src);
          runSrc = src;
          runLen = 1;
        end
        assert (runLen <= int'(holdLen(src)) + 1)
          else reportFailure($sformatf("Port %0d kept the output for %0d flits, over its budget",
                                       src, runLen));
      end
    end
    prevValid = outValid && !rst;
  end

  always @(posedge clk)
  begin
    cycles++;
    if (cycles >= timeoutLimit)
    begin
      $display("Timeout after %0d cycles, the output never drained", cycles);
      $display("Test failed");
      $finish;
    end
  end

  initial
  begin
    rst = 1'b1;
    linkValid = '0;
    for (int p = 0; p < numPorts; p++)
    begin
      linkFlit[p] = '0;
      pktLeft[p] = 0;
      seqNo[p] = 0;
    end
    applyReset();
    repeat (300) stepCycle('1, 40, 1'b0);  // Mixed random traffic
    drainAll();
    repeat (60) stepCycle(5'b00100, 70, 1'b0);
    drainAll();
    assert (grant == '0) else logMismatch("grant", 0, grant);
    repeat (150) stepCycle(5'b01010, 100, 1'b0);
    drainAll();
    for (int i = 0; i < 150; i++)
    begin
      rotateCheck <= (i >= 10) && (i < 140);  // Every channel requests in this window
      stepCycle('1, 100, 1'b0);
    end
    rotateCheck <= 1'b0;
    drainAll();
    repeat (40) stepCycle('1, 100, 1'b1);    // Push into full channels
    drainAll();
    for (int p = 0; p < numPorts; p++)
    begin
      assert (int'(dropCount[p]) == expDrop[p])
        else logMismatch($sformatf("dropCount[%0d]", p), expDrop[p], dropCount[p]);
    end
    assert (expDrop[0] > 0) else reportFailure("No flit was dropped on port 0 during overflow");
    applyReset();
    otherCount += DUT.arbiter.props.failCount;
    $display("Errors: %0d mismatches, %0d other failures", mismatchCount, otherCount);
    if (mismatchCount + otherCount == 0)
      $display("Test completed successfully");
    else
      $display("Test failed");
    $finish;
  end

endmodule

// File: compile.f
logic/nocPkg.sv
logic/inputChannel.sv
logic/outputArbiter.sv
logic/flitSwitch.sv
logic/routerOutputStage.sv
tb/arbiter_properties.sv
tb/routerOutputStageTb.sv

// File: Bender.yml
package:
  name: router_output_stage

sources:
  - logic/nocPkg.sv
  - logic/inputChannel.sv
  - logic/outputArbiter.sv
  - logic/flitSwitch.sv
  - logic/routerOutputStage.sv
  - target: test
    files:
      - tb/arbiter_properties.sv
      - tb/routerOutputStageTb.sv
